//--- jsp_cases.txt
# sel space avail hcnt host0 host1 host2 host3 fifo0 fifo1 fifo2 fifo3 (all hex)
# avail is the number of fifo bytes loaded into the BIU model, at most 4
1 4 0 0 11 22 33 44 00 00 00 00
1 4 4 4 a1 b2 c3 d4 5a 6b 7c 8d
1 2 3 4 01 02 03 04 ff 80 7f 00
1 0 1 3 de ad be ef 3c 00 00 00
1 f 2 2 55 aa 55 aa 12 34 00 00
1 3 4 7 81 42 24 18 e7 db bd 7e
1 1 0 1 c0 ff ee 00 00 00 00 00
0 4 4 4 99 88 77 66 10 20 30 40
1 4 1 0 13 57 9b df 96 00 00 00
1 8 4 f 0f f0 3c c3 00 01 02 03
1 2 2 1 6e 00 11 00 a5 5a 00 00
0 f 3 4 77 77 77 77 c1 c2 c3 00
1 4 4 4 fe dc ba 98 76 54 32 10
1 1 1 1 80 00 00 00 01 00 00 00
1 c 3 2 4d 2b 00 00 e1 d2 c3 00
1 4 2 3 31 41 59 26 53 58 00 00

//--- flist.f
+incdir+.
jsp_pkg.sv
jsp_wr_path.sv
jsp_rd_path.sv
jsp_core.sv
tb_jsp_sva.sv
tb_jsp.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the JTAG serial port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module tb_jsp \
  -f flist.f \
  --Mdir obj_dir \
  -o tb_jsp

./obj_dir/tb_jsp

//--- tb_jsp.sv
`timescale 1ns/10ps
`default_nettype none

`include "jsp_defs.svh"

module tb_jsp;

  localparam int MAX_CASES   = 32;
  localparam int DATA_BYTES  = 4;                             // Data bytes per scan
  localparam int SCAN_BITS   = `JSP_BYTE_W * (DATA_BYTES + 1); // Count or status byte first
  localparam int CYCLE_LIMIT = 200;                           // Watchdog budget per case

  logic                 tck_i;
  logic                 rst_i;
  logic                 tdi;
  logic                 sel;
  jsp_pkg::tap_ctrl_t   tap;
  jsp_pkg::biu_status_t status;
  jsp_pkg::jsp_byte_t   rdata;
  logic                 tdo;
  logic                 rd_strobe;
  jsp_pkg::biu_wr_t     wr;

  // Case table
  int         n_cases = 0;
  logic       case_sel   [MAX_CASES];
  logic [3:0] case_space [MAX_CASES];
  logic [3:0] case_avail [MAX_CASES];
  logic [3:0] case_hcnt  [MAX_CASES];
  logic [7:0] case_host  [MAX_CASES][DATA_BYTES];
  logic [7:0] case_fifo  [MAX_CASES][DATA_BYTES];

  ////////////////////
  // BIU model
  ////////////////////
  logic       load;                 // Start of a new case
  logic [3:0] load_space;
  logic [3:0] load_fill;
  logic [7:0] fifo_mem [16];        // Filled by the main process
  logic [3:0] fill;                 // Bytes loaded for this case
  logic [3:0] rd_ptr;               // Head of the FIFO
  logic [3:0] free;                 // Free slots
  logic [7:0] wr_log [16];          // Every write seen
  logic [4:0] wr_cnt;

  assign status.bytes_available = fill - rd_ptr;
  assign status.space_available = free;
  assign rdata = fifo_mem[rd_ptr];  // Past the fill level the head shows filler bytes

  always @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      fill   <= '0;
      rd_ptr <= '0;
      free   <= '0;
      wr_cnt <= '0;
    end
    else if (load)
    begin
      fill   <= load_fill;
      rd_ptr <= '0;
      free   <= load_space;
      wr_cnt <= '0;
    end
    else
    begin
      if (rd_strobe)
        rd_ptr <= rd_ptr + 1'b1;    // Drop head
      if (wr.strobe)
      begin
        wr_log[wr_cnt[3:0]] <= wr.data;
        wr_cnt              <= wr_cnt + 1'b1;
        free                <= free - 1'b1;
      end
    end
  end

  jsp_core i_dut (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi),
    .module_select_i (sel),
    .tap_i           (tap),
    .tdo_o           (tdo),
    .biu_status_i    (status),
    .biu_rdata_i     (rdata),
    .biu_rd_strobe_o (rd_strobe),
    .biu_wr_o        (wr)
  );

  initial
  begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  ////////////////////
  // Helpers
  ////////////////////
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic read_cases();
    int    fd;
    string line;
    int    col [12];                  // sel space avail hcnt host0..3 fifo0..3
    fd = $fopen("jsp_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file jsp_cases.txt");
      $display("TEST FAIL");
      $fatal(1);
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line.substr(0, 0) == "#")
        continue;                     // Column header or blank line
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5],
                  col[6], col[7], col[8], col[9], col[10], col[11]) == 12 &&
          n_cases < MAX_CASES)
      begin
        case_sel[n_cases]   = col[0][0];
        case_space[n_cases] = 4'(col[1]);
        case_avail[n_cases] = 4'(col[2]);
        case_hcnt[n_cases]  = 4'(col[3]);
        for (int j = 0; j < DATA_BYTES; j++)
        begin
          case_host[n_cases][j] = 8'(col[4 + j]);
          case_fifo[n_cases][j] = 8'(col[8 + j]);
        end
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  // One DR scan with capture, shifting with a pause halfway, then update
  task automatic run_case(input int k);
    logic [SCAN_BITS-1:0] tx;
    logic [SCAN_BITS-1:0] rx;
    int                   exp_wr;
    tx = {case_host[k][3], case_host[k][2], case_host[k][1], case_host[k][0],
          case_hcnt[k], 4'h0};        // Host count in the upper nibble
    rx = '0;
    for (int j = 0; j < 16; j++)
      fifo_mem[j] = (j < DATA_BYTES) ? case_fifo[k][j] : 8'(j * 37 + 5);
    @(posedge tck_i);
    load       <= 1'b1;
    load_space <= case_space[k];
    load_fill  <= case_avail[k];
    sel        <= case_sel[k];
    @(posedge tck_i);
    load        <= 1'b0;
    tap.capture <= 1'b1;
    for (int b = 0; b < SCAN_BITS; b++)
    begin
      if (b == SCAN_BITS / 2)
      begin
        @(posedge tck_i);
        tap.capture <= 1'b0;
        tap.shift   <= 1'b0;          // Pause-DR
      end
      @(posedge tck_i);
      tap.capture <= 1'b0;
      tap.shift   <= 1'b1;
      tdi         <= tx[b];
      @(negedge tck_i);
      rx[b] = tdo;                    // Bit 0 of output register this cycle
    end
    @(posedge tck_i);
    tap.shift  <= 1'b0;
    tap.update <= 1'b1;
    @(posedge tck_i);
    tap.update <= 1'b0;
    sel        <= 1'b0;
    @(negedge tck_i);

    if (case_sel[k])
    begin
      check("tdo status byte", 32'(rx[7:0]), 32'({case_avail[k], case_space[k]}));
      for (int j = 0; j < int'(case_avail[k]); j++)
        check("tdo data byte", 32'(rx[8*j+8 +: 8]), 32'(case_fifo[k][j]));
      check("read strobe count", 32'(rd_ptr), 32'(case_avail[k]));
      exp_wr = int'(case_space[k]);
      if (int'(case_hcnt[k]) < exp_wr)
        exp_wr = int'(case_hcnt[k]);
      if (DATA_BYTES < exp_wr)
        exp_wr = DATA_BYTES;          // Scan carries only this many data bytes
      check("write count", 32'(wr_cnt), 32'(exp_wr));
      for (int j = 0; j < exp_wr; j++)
        check("biu_wr_o.data", 32'(wr_log[j]), 32'(case_host[k][j]));
    end
    else
    begin
      // Deselected scan leaves the BIU alone
      check("read strobe count", 32'(rd_ptr), 32'h0);
      check("write count", 32'(wr_cnt), 32'h0);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    rst_i      = 1'b1;
    tdi        = 1'b0;
    sel        = 1'b0;
    tap       <= '0;
    load       = 1'b0;
    load_space = '0;
    load_fill  = '0;
    read_cases();
    if (n_cases == 0)
    begin
      $display("The case file holds no usable lines");
      $display("TEST FAIL");
      $fatal(1);
    end
    repeat (16) @(posedge tck_i);
    rst_i <= 1'b0;
    @(negedge tck_i);
    check("biu_wr_o.strobe", 32'(wr.strobe), 32'h0);
    check("biu_rd_strobe_o", 32'(rd_strobe), 32'h0);
    check("tdo_o", 32'(tdo), 32'h0);
    for (int k = 0; k < n_cases; k++)
      run_case(k);
    $display("TEST PASS");
    $finish;
  end

  // Watchdog scaled by the number of cases
  initial
  begin
    wait (n_cases > 0);
    repeat (n_cases * CYCLE_LIMIT + 16) @(posedge tck_i);
    $display("Watchdog timeout, the scans did not finish in time");
    $display("TEST FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- tb_jsp_sva.sv
`timescale 1ns/10ps
`default_nettype none

// Protocol checks on the BIU strobes
module tb_jsp_sva (
  input wire                     tck_i,
  input wire                     rst_i,
  input wire jsp_pkg::tap_ctrl_t tap_i,
  input wire                     rd_strobe_i,
  input wire jsp_pkg::biu_wr_t   wr_i
);

  // Strobes only in shift cycles
  assert property (@(posedge tck_i) disable iff (rst_i)
                   (wr_i.strobe | rd_strobe_i) |-> tap_i.shift)
    else $error("BIU strobe outside a shift cycle");

  // FSMs are idle right after update
  assert property (@(posedge tck_i) disable iff (rst_i)
                   tap_i.update |=> !(wr_i.strobe | rd_strobe_i))
    else $error("BIU strobe in the cycle after update");

  assert property (@(posedge tck_i) disable iff (rst_i)
                   wr_i.strobe |=> !wr_i.strobe)
    else $error("Write strobe wider than one cycle");

  assert property (@(posedge tck_i) disable iff (rst_i)
                   rd_strobe_i |=> !rd_strobe_i)
    else $error("Read strobe wider than one cycle");

endmodule

bind jsp_core tb_jsp_sva i_sva (
  .tck_i       (tck_i),
  .rst_i       (rst_i),
  .tap_i       (tap_i),
  .rd_strobe_i (biu_rd_strobe_o),
  .wr_i        (biu_wr_o)
);

`default_nettype wire

//--- jsp_core.sv
`timescale 1ns/10ps
`default_nettype none

// JTAG serial port data path
// Both directions share the TAP controls and run from the same capture
module jsp_core (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  wire                        tdi_i,
  input  wire                        module_select_i,
  input  wire jsp_pkg::tap_ctrl_t    tap_i,
  output logic                       tdo_o,
  input  wire jsp_pkg::biu_status_t  biu_status_i,
  input  wire jsp_pkg::jsp_byte_t    biu_rdata_i,
  output logic                       biu_rd_strobe_o,
  output jsp_pkg::biu_wr_t           biu_wr_o
);

  jsp_pkg::jsp_count_t space_avail;   // Write side only needs the free count

  assign space_avail = biu_status_i.space_available;

  ////////////////////
  // Write direction
  ////////////////////
  jsp_wr_path i_wr_path (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .module_select_i (module_select_i),
    .tap_i           (tap_i),
    .space_i         (space_avail),
    .biu_wr_o        (biu_wr_o)
  );

  ////////////////////
  // Read direction
  ////////////////////
  jsp_rd_path i_rd_path (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .module_select_i (module_select_i),
    .tap_i           (tap_i),
    .status_i        (biu_status_i),  // Full byte goes out first
    .rdata_i         (biu_rdata_i),
    .tdo_o           (tdo_o),
    .rd_strobe_o     (biu_rd_strobe_o)
  );

endmodule

`default_nettype wire

//--- jsp_rd_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "jsp_defs.svh"

// BIU to host direction
// Sends the status byte first and then the bytes waiting in the BIU FIFO
// The head byte is loaded at the end of the previous byte and acked in rdack
module jsp_rd_path (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  wire                        module_select_i,
  input  wire jsp_pkg::tap_ctrl_t    tap_i,
  input  wire jsp_pkg::biu_status_t  status_i,   // Counts at capture
  input  wire jsp_pkg::jsp_byte_t    rdata_i,    // Head of BIU FIFO
  output logic                       tdo_o,
  output logic                       rd_strobe_o // Drop head, present next
);

  ////////////////////
  // Declarations
  ////////////////////
  jsp_pkg::rd_state_e   state_q;      // FSM state
  jsp_pkg::rd_state_e   state_d;      // Next FSM state
  jsp_pkg::jsp_bitcnt_t bit_cnt_q;    // Bits shifted out of current byte
  jsp_pkg::jsp_count_t  out_cnt_q;    // FIFO bytes not yet loaded
  jsp_pkg::jsp_byte_t   shift_q;      // Output shift register

  logic start;                        // Capture with this module selected
  logic capture_ld;                   // Load status byte and counts
  logic shift_en;                     // Active shift cycle
  logic byte_done;                    // Last bit of a byte this cycle
  logic out_zero;                     // Nothing left to read
  logic reload;                       // Parallel load from rdata_i
  logic cnt_dec;                      // One more FIFO byte consumed

  ////////////////////
  // Decode
  ////////////////////
  assign start      = module_select_i & tap_i.capture;
  assign capture_ld = (state_q == jsp_pkg::rd_idle) & start;
  assign shift_en   = tap_i.shift & (state_q != jsp_pkg::rd_idle);
  assign byte_done  = shift_en & (&bit_cnt_q);
  assign out_zero   = (out_cnt_q == '0);

  // Bit counter is always 0 in rdack so byte ends only hit counts and xfer
  assign reload  = byte_done & ~out_zero;
  assign cnt_dec = reload & (state_q == jsp_pkg::rd_xfer); // Status byte is not counted

  // First shift cycle of a data byte acks the byte already loaded
  assign rd_strobe_o = (state_q == jsp_pkg::rd_rdack) & tap_i.shift & ~out_zero;

  assign tdo_o = shift_q[0];  // LSB first

  ////////////////////
  // Control FSM
  ////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::rd_idle:
        if (start) state_d = jsp_pkg::rd_counts;
      jsp_pkg::rd_counts:
        if (tap_i.update)   state_d = jsp_pkg::rd_idle;
        else if (byte_done) state_d = jsp_pkg::rd_rdack;  // Status byte sent
      jsp_pkg::rd_rdack:
        if (tap_i.update)   state_d = jsp_pkg::rd_idle;
        else if (shift_en)  state_d = jsp_pkg::rd_xfer;   // Single cycle
      jsp_pkg::rd_xfer:
        if (tap_i.update)   state_d = jsp_pkg::rd_idle;
        else if (byte_done) state_d = jsp_pkg::rd_rdack;  // Next data byte
      default:
        state_d = jsp_pkg::rd_idle;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= jsp_pkg::rd_idle;
    else
      state_q <= state_d;
  end

  ////////////////////
  // Bit counter
  ////////////////////
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      bit_cnt_q <= '0;
    else if (capture_ld)
      bit_cnt_q <= '0;            // Align to the status byte
    else if (shift_en)
      bit_cnt_q <= bit_cnt_q + 1'b1;
  end

  ////////////////////
  // Output word counter
  ////////////////////
  // Counts down the bytes the BIU reported at capture
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      out_cnt_q <= '0;
    else if (capture_ld)
      out_cnt_q <= status_i.bytes_available;
    else if (cnt_dec)
      out_cnt_q <= out_cnt_q - 1'b1;
  end

  ////////////////////
  // Output shift register
  ////////////////////
  // Cleared by reset so tdo_o starts at 0
  // A load at a byte end replaces the shift of that cycle
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      shift_q <= '0;
    else if (capture_ld)
      shift_q <= status_i;          // Status struct packs as the status byte
    else if (reload)
      shift_q <= rdata_i;           // Head byte, acked in rdack
    else if (shift_en)
      shift_q <= {1'b0, shift_q[`JSP_BYTE_MSB:1]};
  end

endmodule

`default_nettype wire

//--- jsp_wr_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "jsp_defs.svh"

// Host to BIU direction
// First byte of the scan carries the host byte count in its upper nibble
// Every later byte is written to the BIU while space and host count last
module jsp_wr_path (
  input  wire                      tck_i,
  input  wire                      rst_i,
  input  wire                      tdi_i,
  input  wire                      module_select_i,
  input  wire jsp_pkg::tap_ctrl_t  tap_i,
  input  wire jsp_pkg::jsp_count_t space_i,    // BIU free space
  output jsp_pkg::biu_wr_t         biu_wr_o
);

  ////////////////////
  // Declarations
  ////////////////////
  jsp_pkg::wr_state_e   state_q;      // FSM state
  jsp_pkg::wr_state_e   state_d;      // Next FSM state
  jsp_pkg::jsp_bitcnt_t bit_cnt_q;    // Bits shifted into current byte
  jsp_pkg::jsp_count_t  space_cnt_q;  // BIU slots still free
  jsp_pkg::jsp_count_t  user_cnt_q;   // Bytes the host still wants to send

  // Lower seven bits of the byte being assembled
  // tdi_i supplies the top bit in the 8th shift cycle
  logic [`JSP_BYTE_MSB-1:0] shift_q;

  jsp_pkg::jsp_byte_t byte_in;        // Complete byte in the 8th cycle
  logic               start;          // Capture with this module selected
  logic               shift_en;       // Active shift cycle
  logic               byte_done;      // Last bit of a byte this cycle
  logic               space_zero;
  logic               user_zero;
  logic               wr_en;          // Write strobe to the BIU

  ////////////////////
  // Datapath decode
  ////////////////////
  assign start      = module_select_i & tap_i.capture;
  assign shift_en   = tap_i.shift & (state_q != jsp_pkg::wr_idle); // Pauses hold all state
  assign byte_done  = shift_en & (&bit_cnt_q);
  assign byte_in    = {tdi_i, shift_q};                            // LSB first on the wire
  assign space_zero = (space_cnt_q == '0);
  assign user_zero  = (user_cnt_q == '0);

  // Write only on data bytes and only while both counts allow it
  assign wr_en = (state_q == jsp_pkg::wr_xfer) & byte_done & ~space_zero & ~user_zero;

  always_comb
  begin
    biu_wr_o.strobe = wr_en;
    biu_wr_o.data   = byte_in;  // Valid only with the strobe
  end

  ////////////////////
  // Control FSM
  ////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      jsp_pkg::wr_idle:
        if (start) state_d = jsp_pkg::wr_counts;
      jsp_pkg::wr_counts:
        if (tap_i.update)   state_d = jsp_pkg::wr_idle;
        else if (byte_done) state_d = jsp_pkg::wr_xfer; // Host count byte complete
      jsp_pkg::wr_xfer:
        if (tap_i.update)   state_d = jsp_pkg::wr_idle;
      default:
        state_d = jsp_pkg::wr_idle;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= jsp_pkg::wr_idle;
    else
      state_q <= state_d;
  end

  ////////////////////
  // Bit counter
  ////////////////////
  // Wraps from 7 back to 0 on its own at each byte boundary
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      bit_cnt_q <= '0;
    else if ((state_q == jsp_pkg::wr_idle) && start)
      bit_cnt_q <= '0;
    else if (shift_en)
      bit_cnt_q <= bit_cnt_q + 1'b1;
  end

  ////////////////////
  // Byte counters
  ////////////////////
  // Free space is sampled once per scan at capture
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      space_cnt_q <= '0;
    else if ((state_q == jsp_pkg::wr_idle) && start)
      space_cnt_q <= space_i;
    else if (wr_en)
      space_cnt_q <= space_cnt_q - 1'b1;  // One slot used
  end

  // Host count comes from the upper nibble of the first byte
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      user_cnt_q <= '0;
    else if ((state_q == jsp_pkg::wr_counts) && byte_done)
      user_cnt_q <= byte_in[`JSP_BYTE_MSB -: `JSP_COUNT_W];
    else if (wr_en)
      user_cnt_q <= user_cnt_q - 1'b1;
  end

  ////////////////////
  // Input shift register
  ////////////////////
  // New bits enter at the top and move toward bit 0
  always_ff @(posedge tck_i)
  begin
    if (shift_en)
      shift_q <= {tdi_i, shift_q[`JSP_BYTE_MSB-1:1]};
  end

endmodule

`default_nettype wire

//--- jsp_pkg.sv
`default_nettype none

`include "jsp_defs.svh"

package jsp_pkg;

  ////////////////////
  // Vector types
  ////////////////////
  typedef logic [`JSP_BYTE_W-1:0]   jsp_byte_t;   // Data byte
  typedef logic [`JSP_COUNT_W-1:0]  jsp_count_t;  // FIFO or host byte count
  typedef logic [`JSP_BITCNT_W-1:0] jsp_bitcnt_t; // Bit index in a byte

  ////////////////////
  // FSM states
  ////////////////////
  typedef enum logic [1:0] {wr_idle, wr_counts, wr_xfer} wr_state_e;
  typedef enum logic [1:0] {rd_idle, rd_counts, rd_rdack, rd_xfer} rd_state_e;

  ////////////////////
  // Bundles
  ////////////////////
  typedef struct packed {
    logic capture;  // Capture-DR
    logic shift;    // Shift-DR
    logic update;   // Update-DR
  } tap_ctrl_t;

  // Upper nibble first so the struct is the status byte as sent
  typedef struct packed {
    jsp_count_t bytes_available;  // Fill level, read direction
    jsp_count_t space_available;  // Free slots, write direction
  } biu_status_t;

  typedef struct packed {
    logic      strobe;  // Latch data this cycle
    jsp_byte_t data;
  } biu_wr_t;

endpackage

`default_nettype wire

//--- jsp_defs.svh
`ifndef JSP_DEFS_SVH
`define JSP_DEFS_SVH

////////////////////
// Data widths
////////////////////

// One character moved between the host and the BIU FIFO
`define JSP_BYTE_W 8

// FIFO fill and free counts as reported by the BIU
// Also the width of the host byte count in the first scan byte
`define JSP_COUNT_W 4

// Bit position inside a byte during a DR scan
// 2**JSP_BITCNT_W must equal JSP_BYTE_W
`define JSP_BITCNT_W 3

// Top bit of the byte shift registers
`define JSP_BYTE_MSB (`JSP_BYTE_W-1)

`endif
